// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input logic [cpu_pkg::word_width-1:0] a,
	input logic [cpu_pkg::word_width-1:0] b,
	input cpu_pkg::alu_op_e op,
	input cpu_pkg::opcode_e branch_type,
	output logic [cpu_pkg::word_width-1:0] c,
	output logic bcond
);

	localparam int msb = cpu_pkg::word_width - 1;

	always_comb begin
		case (op)
			cpu_pkg::alu_add: c = a + b;
			cpu_pkg::alu_sub: c = a - b;
			cpu_pkg::alu_and: c = a & b;
			cpu_pkg::alu_orr: c = a | b;
			cpu_pkg::alu_not: c = ~a;
			cpu_pkg::alu_tcp: c = ~a + 1'b1;
			cpu_pkg::alu_shl: c = {a[msb-1:0], 1'b0};
			// arithmetic shift, sign bit kept
			cpu_pkg::alu_shr: c = {a[msb], a[msb:1]};
			// lhi, operand b already carries the upper byte
			cpu_pkg::alu_pass_b: c = b;
			cpu_pkg::alu_cmp: c = a - b;
			default: c = '0;
		endcase
	end

	// branch condition on rs and rt, or rs alone for the sign tests
	always_comb begin
		case (branch_type)
			cpu_pkg::op_bne: bcond = (a != b);
			cpu_pkg::op_beq: bcond = (a == b);
			cpu_pkg::op_bgz: bcond = !a[msb] && (a != '0);
			cpu_pkg::op_blz: bcond = a[msb];
			default: bcond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::opcode_e opcode,
	input cpu_pkg::funct_e funct,
	input logic bcond,
	output logic ir_write,
	output logic pc_write,
	output logic pc_write_cond,
	output logic i_or_d,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output logic pc_to_reg,
	output logic alu_src_a,
	output logic [1:0] alu_src_b,
	output cpu_pkg::alu_op_e alu_op,
	output logic [1:0] pc_src,
	output logic wwd,
	output logic is_halted,
	output cpu_pkg::state_e state
);

	cpu_pkg::state_e next_state;

	assign is_halted = (state == cpu_pkg::st_halted);

	// next state per instruction class
	always_comb begin
		next_state = cpu_pkg::st_fetch;
		case (state)
			// first fetch after reset waits one cycle for the read strobe
			cpu_pkg::st_fetch: next_state = mem_read ? cpu_pkg::st_decode : cpu_pkg::st_fetch;
			cpu_pkg::st_decode: begin
				if (opcode != cpu_pkg::op_jmp && opcode != cpu_pkg::op_jal) begin
					next_state = cpu_pkg::st_execute;
				end
			end
			cpu_pkg::st_execute: begin
				case (opcode)
					cpu_pkg::op_rtype: begin
						if (funct == cpu_pkg::fn_hlt) begin
							next_state = cpu_pkg::st_halted;
						end else if (funct != cpu_pkg::fn_jpr && funct != cpu_pkg::fn_jrl
								&& funct != cpu_pkg::fn_wwd) begin
							next_state = cpu_pkg::st_writeback;
						end
					end
					cpu_pkg::op_adi, cpu_pkg::op_ori, cpu_pkg::op_lhi:
						next_state = cpu_pkg::st_writeback;
					cpu_pkg::op_lwd, cpu_pkg::op_swd: next_state = cpu_pkg::st_memory;
					default: next_state = cpu_pkg::st_fetch;
				endcase
			end
			cpu_pkg::st_memory: begin
				if (opcode == cpu_pkg::op_lwd) begin
					next_state = cpu_pkg::st_writeback;
				end
			end
			cpu_pkg::st_halted: next_state = cpu_pkg::st_halted;
			default: next_state = cpu_pkg::st_fetch;
		endcase
	end

	// bus strobes follow the state they belong to
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu_pkg::st_fetch;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			state <= next_state;
			mem_read <= (next_state == cpu_pkg::st_fetch)
				|| (next_state == cpu_pkg::st_memory && opcode == cpu_pkg::op_lwd);
			mem_write <= (next_state == cpu_pkg::st_memory && opcode == cpu_pkg::op_swd);
		end
	end

	always_comb begin
		ir_write = 1'b0;
		pc_write = 1'b0;
		pc_write_cond = 1'b0;
		i_or_d = 1'b0;
		reg_write = 1'b0;
		mem_to_reg = 1'b0;
		pc_to_reg = 1'b0;
		alu_src_a = 1'b0;
		alu_src_b = 2'd0;
		alu_op = cpu_pkg::alu_add;
		pc_src = 2'd0;
		wwd = 1'b0;
		case (state)
			cpu_pkg::st_fetch: begin
				ir_write = mem_read;
				pc_write = mem_read;
			end
			cpu_pkg::st_decode: begin
				// branch target from the incremented pc
				alu_src_b = 2'd1;
				if (opcode == cpu_pkg::op_jmp || opcode == cpu_pkg::op_jal) begin
					pc_write = 1'b1;
					pc_src = 2'd2;
					reg_write = (opcode == cpu_pkg::op_jal);
					pc_to_reg = (opcode == cpu_pkg::op_jal);
				end
			end
			cpu_pkg::st_execute: begin
				alu_src_a = 1'b1;
				case (opcode)
					cpu_pkg::op_rtype: begin
						case (funct)
							cpu_pkg::fn_jpr, cpu_pkg::fn_jrl: begin
								pc_write = 1'b1;
								pc_src = 2'd3;
								reg_write = (funct == cpu_pkg::fn_jrl);
								pc_to_reg = (funct == cpu_pkg::fn_jrl);
							end
							cpu_pkg::fn_wwd: wwd = 1'b1;
							default: alu_op = cpu_pkg::alu_op_e'({1'b0, funct[2:0]});
						endcase
					end
					cpu_pkg::op_adi, cpu_pkg::op_lwd, cpu_pkg::op_swd: alu_src_b = 2'd1;
					cpu_pkg::op_ori: begin
						alu_src_b = 2'd2;
						alu_op = cpu_pkg::alu_orr;
					end
					cpu_pkg::op_lhi: begin
						alu_src_b = 2'd3;
						alu_op = cpu_pkg::alu_pass_b;
					end
					cpu_pkg::op_bne, cpu_pkg::op_beq, cpu_pkg::op_bgz, cpu_pkg::op_blz: begin
						alu_op = cpu_pkg::alu_cmp;
						pc_write_cond = bcond;
						pc_src = 2'd1;
					end
					default: alu_op = cpu_pkg::alu_add;
				endcase
			end
			cpu_pkg::st_memory: i_or_d = 1'b1;
			cpu_pkg::st_writeback: begin
				reg_write = 1'b1;
				mem_to_reg = (opcode == cpu_pkg::op_lwd);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter logic [cpu_pkg::word_width-1:0] reset_pc = '0
) (
	input logic clk,
	input logic rst_n,
	input logic [cpu_pkg::word_width-1:0] rdata,
	output logic [cpu_pkg::word_width-1:0] address,
	output logic [cpu_pkg::word_width-1:0] wdata,
	output logic [cpu_pkg::word_width-1:0] num_inst,
	output logic [cpu_pkg::word_width-1:0] output_port,
	output logic read_m,
	output logic write_m,
	output logic is_halted
);

	logic ir_write;
	logic pc_write;
	logic pc_write_cond;
	logic i_or_d;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic mem_to_reg;
	logic pc_to_reg;
	logic alu_src_a;
	logic [1:0] alu_src_b;
	logic [1:0] pc_src;
	logic wwd;
	logic bcond;
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e funct;
	// visible for bound checks
	cpu_pkg::state_e state;

	control_unit u_control (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.funct(funct),
		.bcond(bcond),
		.ir_write(ir_write),
		.pc_write(pc_write),
		.pc_write_cond(pc_write_cond),
		.i_or_d(i_or_d),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.pc_to_reg(pc_to_reg),
		.alu_src_a(alu_src_a),
		.alu_src_b(alu_src_b),
		.alu_op(alu_op),
		.pc_src(pc_src),
		.wwd(wwd),
		.is_halted(is_halted),
		.state(state)
	);

	datapath #(
		.reset_pc(reset_pc)
	) u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.ir_write(ir_write),
		.pc_write(pc_write),
		.pc_write_cond(pc_write_cond),
		.i_or_d(i_or_d),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.pc_to_reg(pc_to_reg),
		.alu_src_a(alu_src_a),
		.alu_src_b(alu_src_b),
		.alu_op(alu_op),
		.pc_src(pc_src),
		.wwd(wwd),
		.rdata(rdata),
		.opcode(opcode),
		.funct(funct),
		.bcond(bcond),
		.address(address),
		.wdata(wdata),
		.read_m(read_m),
		.write_m(write_m),
		.num_inst(num_inst),
		.output_port(output_port)
	);

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// data and address width
	localparam int word_width = 16;

	// architectural registers
	localparam int reg_count = 4;

	// instruction bits 15 to 12
	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_e;

	// r-type function field, bits 5 to 0
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} funct_e;

	// low eight values line up with the arithmetic functs
	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_orr = 4'd3,
		alu_not = 4'd4,
		alu_tcp = 4'd5,
		alu_shl = 4'd6,
		alu_shr = 4'd7,
		alu_pass_b = 4'd8,
		alu_cmp = 4'd9
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch = 3'd0,
		st_decode = 3'd1,
		st_execute = 3'd2,
		st_memory = 3'd3,
		st_writeback = 3'd4,
		st_halted = 3'd5
	} state_e;

endpackage

`default_nettype wire

// File: logic/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
	parameter logic [cpu_pkg::word_width-1:0] reset_pc = '0
) (
	input logic clk,
	input logic rst_n,
	input logic ir_write,
	input logic pc_write,
	input logic pc_write_cond,
	input logic i_or_d,
	input logic mem_read,
	input logic mem_write,
	input logic reg_write,
	input logic mem_to_reg,
	input logic pc_to_reg,
	input logic alu_src_a,
	input logic [1:0] alu_src_b,
	input cpu_pkg::alu_op_e alu_op,
	input logic [1:0] pc_src,
	input logic wwd,
	input logic [cpu_pkg::word_width-1:0] rdata,
	output cpu_pkg::opcode_e opcode,
	output cpu_pkg::funct_e funct,
	output logic bcond,
	output logic [cpu_pkg::word_width-1:0] address,
	output logic [cpu_pkg::word_width-1:0] wdata,
	output logic read_m,
	output logic write_m,
	output logic [cpu_pkg::word_width-1:0] num_inst,
	output logic [cpu_pkg::word_width-1:0] output_port
);

	localparam int idx_w = $clog2(cpu_pkg::reg_count);
	// return address register for jal and jrl
	localparam logic [idx_w-1:0] link_reg = idx_w'(2);

	logic [cpu_pkg::word_width-1:0] pc;
	logic [cpu_pkg::word_width-1:0] ir;
	logic [cpu_pkg::word_width-1:0] mdr;
	logic [cpu_pkg::word_width-1:0] alu_out;
	logic [cpu_pkg::word_width-1:0] read_out1;
	logic [cpu_pkg::word_width-1:0] read_out2;
	logic [cpu_pkg::word_width-1:0] alu_a;
	logic [cpu_pkg::word_width-1:0] alu_b;
	logic [cpu_pkg::word_width-1:0] alu_c;
	logic [cpu_pkg::word_width-1:0] next_pc;
	logic [cpu_pkg::word_width-1:0] write_data;
	logic [idx_w-1:0] write_reg;

	assign opcode = cpu_pkg::opcode_e'(ir[15:12]);
	assign funct = cpu_pkg::funct_e'(ir[5:0]);

	// operand selection
	assign alu_a = alu_src_a ? read_out1 : pc;
	always_comb begin
		case (alu_src_b)
			2'd0: alu_b = read_out2;
			2'd1: alu_b = {{8{ir[7]}}, ir[7:0]};
			2'd2: alu_b = {8'h00, ir[7:0]};
			default: alu_b = {ir[7:0], 8'h00};
		endcase
	end

	always_comb begin
		case (pc_src)
			2'd0: next_pc = pc + 1'b1;
			2'd1: next_pc = alu_out;
			2'd2: next_pc = {pc[15:12], ir[11:0]};
			default: next_pc = read_out1;
		endcase
	end

	// r-type writes rd, everything else rt
	assign write_reg = pc_to_reg ? link_reg
		: (opcode == cpu_pkg::op_rtype) ? ir[7:6] : ir[9:8];
	assign write_data = pc_to_reg ? pc : (mem_to_reg ? mdr : alu_out);

	assign address = i_or_d ? alu_out : pc;
	assign wdata = read_out2;
	assign read_m = mem_read;
	assign write_m = mem_write;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (pc_write || pc_write_cond) begin
				pc <= next_pc;
			end
			if (ir_write) begin
				num_inst <= num_inst + 1'b1;
			end
			if (wwd) begin
				output_port <= read_out1;
			end
		end
	end

	// branch target stays put while the compare runs
	always_ff @(posedge clk) begin
		if (ir_write) begin
			ir <= rdata;
		end
		mdr <= rdata;
		if (alu_op != cpu_pkg::alu_cmp) begin
			alu_out <= alu_c;
		end
	end

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.read1(ir[11:10]),
		.read2(ir[9:8]),
		.write_reg(write_reg),
		.write_data(write_data),
		.reg_write(reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(alu_op),
		.branch_type(opcode),
		.c(alu_c),
		.bcond(bcond)
	);

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input logic clk,
	input logic rst_n,
	input logic [$clog2(cpu_pkg::reg_count)-1:0] read1,
	input logic [$clog2(cpu_pkg::reg_count)-1:0] read2,
	input logic [$clog2(cpu_pkg::reg_count)-1:0] write_reg,
	input logic [cpu_pkg::word_width-1:0] write_data,
	input logic reg_write,
	output logic [cpu_pkg::word_width-1:0] read_out1,
	output logic [cpu_pkg::word_width-1:0] read_out2
);

	logic [cpu_pkg::word_width-1:0] regs [cpu_pkg::reg_count];

	// asynchronous read ports
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

	// no writes land while reset is held
	always_ff @(posedge clk) begin
		if (reg_write && rst_n) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cpu -f verilog.f -o sim_cpu
out=$(./obj_dir/sim_cpu)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
	exit 0
else
	exit 1
fi

// File: tb/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
	input logic clk,
	input logic rst_n,
	input logic read_m,
	input logic write_m,
	input logic is_halted,
	input logic [15:0] num_inst,
	input cpu_pkg::state_e state
);

	// one strobe at a time on the shared bus
	strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(read_m && write_m))
		else $error("read_m and write_m high together");

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) is_halted |=> is_halted)
		else $error("is_halted dropped without reset");

	count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		num_inst >= $past(num_inst))
		else $error("num_inst decreased");

	halted_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == cpu_pkg::st_halted |-> !read_m && !write_m)
		else $error("bus strobe in halted state");

endmodule

bind cpu cpu_asserts u_cpu_asserts (.*);

`default_nettype wire

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	logic clk;
	logic rst_n;
	logic [15:0] rdata;
	logic [15:0] address;
	logic [15:0] wdata;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic read_m;
	logic write_m;
	logic is_halted;

	logic [15:0] image [256];
	logic [15:0] mem [256];
	logic [15:0] data_word [4];
	logic [15:0] exp_q [$];
	logic [15:0] last_pushed;
	logic [15:0] last_out;
	logic [15:0] exp_store;
	logic [31:0] rng;
	int p;
	int exec_count;
	int prog_len;
	int store_count;
	bit seen_release;
	bit halt_checked;

	cpu #(.reset_pc(16'h0000)) u_cpu (
		.clk(clk),
		.rst_n(rst_n),
		.rdata(rdata),
		.address(address),
		.wdata(wdata),
		.num_inst(num_inst),
		.output_port(output_port),
		.read_m(read_m),
		.write_m(write_m),
		.is_halted(is_halted)
	);

	always #50 clk = ~clk;

	// single-port memory reloaded from the image during reset
	assign rdata = read_m ? mem[address[7:0]] : 16'h0000;
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				mem[i] <= image[i];
			end
		end else if (write_m) begin
			mem[address[7:0]] <= wdata;
		end
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [15:0] enc_r(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
			logic [5:0] f);
		return {4'hf, rs, rt, rd, f};
	endfunction

	function automatic logic [15:0] enc_i(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
			logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// expected r-type result with sign-keeping shr
	function automatic logic [15:0] alu_model(int f, logic [15:0] a, logic [15:0] b);
		case (f)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return ~a;
			5: return -a;
			6: return {a[14:0], 1'b0};
			default: return {a[15], a[15:1]};
		endcase
	endfunction

	task automatic stop_failed();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_value(string name, logic [15:0] exp, logic [15:0] got);
		$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
		stop_failed();
	endtask

	task automatic report_text(string what);
		$display("%0t %s", $time, what);
		stop_failed();
	endtask

	task automatic emit(logic [15:0] word);
		image[p] = word;
		p++;
		exec_count++;
	endtask

	// wrong-path pair whose output no check expects
	task automatic emit_bad();
		image[p] = enc_i(cpu_pkg::op_lhi, 2'd0, 2'd3, 8'hee);
		image[p + 1] = enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
		p += 2;
	endtask

	task automatic expect_out(logic [15:0] v);
		if (v != last_pushed) begin
			exp_q.push_back(v);
		end
		last_pushed = v;
	endtask

	task automatic emit_mark(logic [7:0] m);
		emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd3, m));
		emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out({m, 8'h00});
	endtask

	task automatic build_program();
		logic [3:0] br_op [4];
		logic [15:0] ret;
		br_op = '{cpu_pkg::op_bne, cpu_pkg::op_beq, cpu_pkg::op_bgz, cpu_pkg::op_blz};
		for (int i = 0; i < 256; i++) begin
			image[i] = {i[7:0], ~i[7:0]};
		end
		rng = 32'd86880;
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			data_word[k] = rng[15:0];
			image[8'h60 + k] = rng[15:0];
		end
		emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd0, 8'h00));
		for (int h = 0; h < 2; h++) begin
			emit(enc_i(cpu_pkg::op_lwd, 2'd0, 2'd1, 8'(8'h60 + 2 * h)));
			emit(enc_i(cpu_pkg::op_lwd, 2'd0, 2'd2, 8'(8'h61 + 2 * h)));
			for (int f = 4 * h; f < 4 * h + 4; f++) begin
				emit(enc_r(2'd1, 2'd2, 2'd3, 6'(f)));
				emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd));
				expect_out(alu_model(f, data_word[2 * h], data_word[2 * h + 1]));
			end
		end
		emit(enc_i(cpu_pkg::op_adi, 2'd1, 2'd3, 8'h85));
		emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out(data_word[2] + 16'hff85);
		emit(enc_i(cpu_pkg::op_ori, 2'd1, 2'd3, 8'h85));
		emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out(data_word[2] | 16'h0085);
		emit_mark(8'h5a);
		// store the sum and read it back
		exp_store = data_word[2] + data_word[3];
		emit(enc_r(2'd1, 2'd2, 2'd3, cpu_pkg::fn_add));
		emit(enc_i(cpu_pkg::op_swd, 2'd0, 2'd3, 8'h70));
		emit(enc_i(cpu_pkg::op_lwd, 2'd0, 2'd3, 8'h70));
		emit(enc_r(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out(exp_store);
		// positive r1 and negative r2 for the sign tests
		emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd1, 8'h01));
		emit(enc_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'hff));
		// branches that are taken
		emit(enc_i(br_op[0], 2'd1, 2'd2, 8'd2));
		emit_bad();
		emit_mark(8'h11);
		emit(enc_i(br_op[1], 2'd1, 2'd1, 8'd2));
		emit_bad();
		emit_mark(8'h12);
		emit(enc_i(br_op[2], 2'd1, 2'd0, 8'd2));
		emit_bad();
		emit_mark(8'h13);
		emit(enc_i(br_op[3], 2'd2, 2'd0, 8'd2));
		emit_bad();
		emit_mark(8'h14);
		// branches that fall through
		emit(enc_i(br_op[0], 2'd1, 2'd1, 8'd2));
		emit_mark(8'h21);
		emit(enc_i(br_op[1], 2'd1, 2'd2, 8'd2));
		emit_mark(8'h22);
		emit(enc_i(br_op[2], 2'd2, 2'd0, 8'd2));
		emit_mark(8'h23);
		emit(enc_i(br_op[3], 2'd1, 2'd0, 8'd2));
		emit_mark(8'h24);
		emit({cpu_pkg::op_jmp, 12'(p + 3)});
		emit_bad();
		emit_mark(8'h31);
		ret = 16'(p + 1);
		emit({cpu_pkg::op_jal, 12'(p + 3)});
		emit_bad();
		emit(enc_r(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out(ret);
		emit(enc_i(cpu_pkg::op_adi, 2'd0, 2'd1, 8'(p + 4)));
		emit(enc_r(2'd1, 2'd0, 2'd0, cpu_pkg::fn_jpr));
		emit_bad();
		emit_mark(8'h32);
		emit(enc_i(cpu_pkg::op_adi, 2'd0, 2'd1, 8'(p + 4)));
		ret = 16'(p + 1);
		emit(enc_r(2'd1, 2'd0, 2'd0, cpu_pkg::fn_jrl));
		emit_bad();
		emit(enc_r(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd));
		expect_out(ret);
		emit(enc_r(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt));
		prog_len = p;
	endtask

	// outputs sampled on the falling edge
	always @(negedge clk) begin
		if (rst_n && !seen_release) begin
			seen_release = 1'b1;
			assert (!read_m) else report_value("read_m", 16'h0, {15'h0, read_m});
			assert (!write_m) else report_value("write_m", 16'h0, {15'h0, write_m});
			assert (!is_halted) else report_value("is_halted", 16'h0, {15'h0, is_halted});
			assert (num_inst == 16'h0) else report_value("num_inst", 16'h0, num_inst);
			assert (output_port == 16'h0) else report_value("output_port", 16'h0, output_port);
		end
		if (rst_n && output_port != last_out) begin
			assert (exp_q.size() != 0) else report_text("output_port changed with no value left");
			assert (output_port == exp_q[0]) else report_value("output_port", exp_q[0], output_port);
			void'(exp_q.pop_front());
			last_out = output_port;
		end
		if (rst_n && write_m) begin
			store_count++;
			assert (address == 16'h0070) else report_value("address", 16'h0070, address);
			assert (wdata == exp_store) else report_value("wdata", exp_store, wdata);
		end
		if (halt_checked) begin
			assert (!read_m && !write_m) else report_text("bus active after halt");
			assert (num_inst == 16'(exec_count)) else
				report_value("num_inst", 16'(exec_count), num_inst);
		end
		if (is_halted && !halt_checked) begin
			halt_checked = 1'b1;
			assert (num_inst == 16'(exec_count)) else
				report_value("num_inst", 16'(exec_count), num_inst);
			assert (exp_q.size() == 0) else report_text("halted before all outputs appeared");
			assert (store_count == 1) else report_text("store count is not one");
		end
	end

	initial begin
		wait (prog_len > 0);
		#((prog_len * 40 + 8) * 100);
		$display("watchdog expired before the core halted");
		stop_failed();
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		p = 0;
		exec_count = 0;
		prog_len = 0;
		store_count = 0;
		last_pushed = 16'h0;
		last_out = 16'h0;
		seen_release = 1'b0;
		halt_checked = 1'b0;
		build_program();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		wait (halt_checked);
		repeat (6) @(posedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
logic/cpu_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/control_unit.sv
logic/datapath.sv
logic/cpu.sv
tb/cpu_asserts.sv
tb/tb_cpu.sv
